/* hw/pwr_pkg.sv */
/*
 * Power sequencer shared definitions
 * Rail indices, host register map, identification bytes, default timer
 * widths and the structs passed between the sequencer blocks
 */
package pwr_pkg;

	localparam int RAIL_COUNT = 9;

	// Rails in power-up order
	localparam int RAIL_ATX    = 0;
	localparam int RAIL_MISCIO = 1;
	localparam int RAIL_VDNA   = 2;
	localparam int RAIL_AVDD   = 3;
	localparam int RAIL_VIOA   = 4;
	localparam int RAIL_VDDA   = 5;
	localparam int RAIL_VCSA   = 6;
	localparam int RAIL_VPPAB  = 7;
	localparam int RAIL_VDDR   = 8;

	// A timer ends when the top bit of its counter sets
	localparam int DEF_DELAY_BITS    = 17;
	localparam int DEF_WAIT_BITS     = 24;
	localparam int DEF_ATX_WAIT_BITS = 27;

	localparam logic [7:0] REG_VERSION  = 8'h00;
	localparam logic [7:0] REG_CLR_ERR  = 8'h03;
	localparam logic [7:0] REG_STATUS   = 8'h07;
	localparam logic [7:0] REG_EN_LO    = 8'h08;
	localparam logic [7:0] REG_EN_HI    = 8'h09;
	localparam logic [7:0] REG_PG_LO    = 8'h0A;
	localparam logic [7:0] REG_PG_HI    = 8'h0B;
	localparam logic [7:0] REG_VENDOR0  = 8'h0C;
	localparam logic [7:0] REG_VENDOR1  = 8'h0D;
	localparam logic [7:0] REG_VENDOR2  = 8'h0E;
	localparam logic [7:0] REG_VENDOR3  = 8'h0F;
	localparam logic [7:0] REG_FAIL_LO  = 8'h18;
	localparam logic [7:0] REG_FAIL_HI  = 8'h19;
	localparam logic [7:0] REG_OVERRIDE = 8'h33;

	localparam logic [7:0] FPGA_VERSION = 8'h00;
	// Byte 0 is read at REG_VENDOR0
	localparam logic [3:0][7:0] VENDOR_ID = {8'h20, 8'h53, 8'h43, 8'h52};

	typedef logic [RAIL_COUNT-1:0] rail_vec_t;
	typedef logic [3:0] rail_idx_t;

	typedef struct packed {
		logic wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic atx_force;
		logic atx_debug_force;
		logic reg_debug_force;
	} override_t;

	typedef struct packed {
		logic wait_err;
		logic operation_err;
		logic err_found;
	} fault_t;

	typedef struct packed {
		logic atx_en_n;
		logic miscio_en;
		logic vdna_en;
		logic avdd_en;
		logic vioa_en;
		logic vdda_en;
		logic vcsa_en;
		logic vppab_en;
		logic vddrab_en;
		logic vttab_en;
	} rail_en_t;

	// Index of the lowest set rail bit, 0 when none is set
	function automatic rail_idx_t lowest_rail(input rail_vec_t v);
		rail_idx_t idx;
		idx = '0;
		for (int i = RAIL_COUNT - 1; i >= 0; i--) begin
			if (v[i]) begin
				idx = rail_idx_t'(i);
			end
		end
		return idx;
	endfunction

endpackage

/* hw/pg_sync.sv */
/*
 * Input synchronizer
 * Samples the rail power-good pins and system enable, then passes both
 * through two sync stages and flags a falling system enable
 */
`timescale 1ns/1ps

module pg_sync (
	input  logic                clk_in,
	input  logic                rst_n,
	input  logic                sysen,
	input  pwr_pkg::rail_vec_t  pg,
	input  pwr_pkg::override_t  override,
	output pwr_pkg::rail_vec_t  pg_raw,
	output pwr_pkg::rail_vec_t  pg_s,
	output logic                sysen_buf,
	output logic                sysen_s,
	output logic                sysen_fall
);

	pwr_pkg::rail_vec_t pg_s1;
	logic sysen_s1;

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			pg_raw <= '0;
			pg_s1 <= '0;
			pg_s <= '0;
			sysen_buf <= 1'b0;
			sysen_s1 <= 1'b0;
			sysen_s <= 1'b0;
			sysen_fall <= 1'b0;
		end else begin
			pg_raw <= pg;
			pg_s1 <= pg_raw;
			pg_s <= pg_s1;
			// ATX force lets the host run the sequence without the BMC
			sysen_buf <= sysen | override.atx_force;
			sysen_s1 <= sysen_buf;
			sysen_s <= sysen_s1;
			sysen_fall <= sysen_s1 & ~sysen_buf;
		end
	end

endmodule

/* hw/rail_sequencer.sv */
/*
 * Rail enable sequencer
 * Brings rails up in order with a settle delay after each power-good,
 * and takes them down in reverse order as the rail above loses power-good
 */
`timescale 1ns/1ps

module rail_sequencer #(
	parameter int DELAY_BITS = pwr_pkg::DEF_DELAY_BITS
) (
	input  logic                clk_in,
	input  logic                rst_n,
	input  logic                sysen_s,
	input  pwr_pkg::rail_vec_t  pg_s,
	input  logic                err_found,
	input  logic                clear_err,
	output pwr_pkg::rail_vec_t  en,
	output pwr_pkg::rail_vec_t  delay_done,
	output logic                settling
);

	pwr_pkg::rail_vec_t cand;
	pwr_pkg::rail_vec_t next_en;
	pwr_pkg::rail_idx_t sel;
	logic [DELAY_BITS-1:0] d_count;

	// Rails that are up but still inside their settle window
	assign cand = en & pg_s & ~delay_done;
	assign sel = pwr_pkg::lowest_rail(cand);
	assign settling = sysen_s & ~err_found & (|cand);

	always_comb begin
		next_en[pwr_pkg::RAIL_ATX] = sysen_s | pg_s[pwr_pkg::RAIL_ATX + 1];
		// Up after the rail below has settled, held while the rail above is good
		for (int i = pwr_pkg::RAIL_ATX + 1; i < pwr_pkg::RAIL_VDDR; i++) begin
			next_en[i] = (sysen_s & delay_done[i-1]) | pg_s[i+1];
		end
		next_en[pwr_pkg::RAIL_VDDR] = sysen_s & delay_done[pwr_pkg::RAIL_VDDR - 1];
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			en <= '0;
			delay_done <= '0;
			d_count <= '0;
		end else begin
			// A latched error shuts every rail off
			en <= err_found ? '0 : next_en;

			if (!sysen_s || err_found) begin
				delay_done <= '0;
				d_count <= '0;
			end else if (clear_err || !(|cand)) begin
				d_count <= '0;
			end else if (d_count[DELAY_BITS-1]) begin
				d_count <= '0;
				delay_done[sel] <= 1'b1;
			end else begin
				d_count <= d_count + 1'b1;
			end
		end
	end

endmodule

/* hw/fault_monitor.sv */
/*
 * Sequencing fault monitor
 * Times each enabled rail waiting for power-good, watches settled rails
 * for lost power-good, latches the error and snapshots the failing rails
 */
`timescale 1ns/1ps

module fault_monitor #(
	parameter int WAIT_BITS     = pwr_pkg::DEF_WAIT_BITS,
	parameter int ATX_WAIT_BITS = pwr_pkg::DEF_ATX_WAIT_BITS
) (
	input  logic                clk_in,
	input  logic                rst_n,
	input  pwr_pkg::rail_vec_t  en,
	input  pwr_pkg::rail_vec_t  pg_s,
	input  pwr_pkg::rail_vec_t  pg_raw,
	input  pwr_pkg::rail_vec_t  delay_done,
	input  logic                settling,
	input  logic                clear_err,
	input  logic                sysen_s,
	output pwr_pkg::fault_t     fault,
	output pwr_pkg::rail_vec_t  fail_detail
);

	localparam int CNT_BITS = (ATX_WAIT_BITS > WAIT_BITS) ? ATX_WAIT_BITS : WAIT_BITS;

	pwr_pkg::rail_vec_t waiting;
	pwr_pkg::rail_idx_t sel;
	logic [CNT_BITS-1:0] w_count;
	logic timeout;
	logic err_found_d;

	assign waiting = en & ~pg_s;
	assign sel = pwr_pkg::lowest_rail(waiting);

	// ATX supplies are allowed a much longer ramp
	assign timeout = (sel == pwr_pkg::rail_idx_t'(pwr_pkg::RAIL_ATX)) ?
		w_count[ATX_WAIT_BITS-1] : w_count[WAIT_BITS-1];

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			fault <= '0;
			fail_detail <= '0;
			w_count <= '0;
			err_found_d <= 1'b0;
		end else if (clear_err) begin
			fault <= '0;
			fail_detail <= '0;
			w_count <= '0;
			err_found_d <= 1'b0;
		end else begin
			err_found_d <= fault.err_found;

			if (!sysen_s || fault.err_found || settling || !(|waiting)) begin
				w_count <= '0;
			end else if (timeout) begin
				w_count <= '0;
				fault.wait_err <= 1'b1;
			end else begin
				w_count <= w_count + 1'b1;
			end

			// A settled rail must keep its power-good
			if (|(delay_done & ~pg_s)) begin
				fault.operation_err <= 1'b1;
			end

			if (fault.wait_err || fault.operation_err) begin
				fault.err_found <= 1'b1;
			end

			// Enables are still pre-error on the first error cycle
			if (fault.err_found && !err_found_d) begin
				fail_detail <= en ^ pg_raw;
			end
		end
	end

endmodule

/* hw/ctrl_regs.sv */
/*
 * Host register space
 * Byte-wide status, identification and override registers behind a
 * plain address and write strobe port, plus the error clear pulse
 */
`timescale 1ns/1ps

module ctrl_regs (
	input  logic                clk_in,
	input  logic                rst_n,
	input  pwr_pkg::reg_req_t   host,
	input  logic                sysen_fall,
	input  logic                sysen_buf,
	input  pwr_pkg::rail_vec_t  en,
	input  pwr_pkg::rail_vec_t  pg_raw,
	input  pwr_pkg::rail_vec_t  delay_done,
	input  pwr_pkg::rail_vec_t  fail_detail,
	input  pwr_pkg::fault_t     fault,
	output logic [7:0]          rdata,
	output pwr_pkg::override_t  override,
	output logic                clear_err
);

	logic [7:0] rd_next;
	logic clr_wr;

	// Any write to the clear address counts, the data is ignored
	assign clr_wr = host.wr && (host.addr == pwr_pkg::REG_CLR_ERR);

	always_comb begin
		case (host.addr)
			pwr_pkg::REG_VERSION:  rd_next = pwr_pkg::FPGA_VERSION;
			pwr_pkg::REG_STATUS: begin
				rd_next = {3'b000, fault.wait_err, fault.operation_err, fault.err_found,
					sysen_buf, delay_done[pwr_pkg::RAIL_VDDR]};
			end
			pwr_pkg::REG_EN_LO:    rd_next = en[7:0];
			pwr_pkg::REG_EN_HI:    rd_next = {7'b0, en[8]};
			pwr_pkg::REG_PG_LO:    rd_next = pg_raw[7:0];
			pwr_pkg::REG_PG_HI:    rd_next = {7'b0, pg_raw[8]};
			pwr_pkg::REG_VENDOR0:  rd_next = pwr_pkg::VENDOR_ID[0];
			pwr_pkg::REG_VENDOR1:  rd_next = pwr_pkg::VENDOR_ID[1];
			pwr_pkg::REG_VENDOR2:  rd_next = pwr_pkg::VENDOR_ID[2];
			pwr_pkg::REG_VENDOR3:  rd_next = pwr_pkg::VENDOR_ID[3];
			pwr_pkg::REG_FAIL_LO:  rd_next = fail_detail[7:0];
			pwr_pkg::REG_FAIL_HI:  rd_next = {7'b0, fail_detail[8]};
			pwr_pkg::REG_OVERRIDE: begin
				rd_next = {3'b000, override.reg_debug_force, override.atx_debug_force,
					2'b00, override.atx_force};
			end
			default:               rd_next = 8'h00;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			override <= '0;
			clear_err <= 1'b0;
			rdata <= 8'h00;
		end else begin
			if (host.wr && (host.addr == pwr_pkg::REG_OVERRIDE)) begin
				override.atx_force <= host.wdata[0];
				override.atx_debug_force <= host.wdata[3];
				override.reg_debug_force <= host.wdata[4];
			end
			// Errors also clear when the system enable goes away
			clear_err <= clr_wr | sysen_fall;
			rdata <= rd_next;
		end
	end

endmodule

/* hw/power_outputs.sv */
/*
 * Pin output stage
 * Registers the rail enables with the debug forces applied and derives
 * system good, LPC reset and the CPU standby reset
 */
`timescale 1ns/1ps

module power_outputs (
	input  logic                clk_in,
	input  logic                rst_n,
	input  pwr_pkg::rail_vec_t  en,
	input  pwr_pkg::rail_vec_t  delay_done,
	input  pwr_pkg::override_t  override,
	input  logic                bmc_boot_complete_n,
	output pwr_pkg::rail_en_t   rail_en,
	output logic                sysgood,
	output logic                lpc_rst,
	output logic                cpu_stby_rst_assert
);

	logic sysgood_buf;
	logic dbg;

	assign dbg = override.reg_debug_force;

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			rail_en <= '{atx_en_n: 1'b1, default: 1'b0};
			sysgood_buf <= 1'b0;
			sysgood <= 1'b0;
			lpc_rst <= 1'b0;
			cpu_stby_rst_assert <= 1'b1;
		end else begin
			// ATX PS_ON is active low
			rail_en.atx_en_n <= ~(en[pwr_pkg::RAIL_ATX] | override.atx_debug_force);
			rail_en.miscio_en <= en[pwr_pkg::RAIL_MISCIO] | dbg;
			rail_en.vdna_en <= en[pwr_pkg::RAIL_VDNA] | dbg;
			rail_en.avdd_en <= en[pwr_pkg::RAIL_AVDD] | dbg;
			rail_en.vioa_en <= en[pwr_pkg::RAIL_VIOA] | dbg;
			rail_en.vdda_en <= en[pwr_pkg::RAIL_VDDA] | dbg;
			rail_en.vcsa_en <= en[pwr_pkg::RAIL_VCSA] | dbg;
			rail_en.vppab_en <= en[pwr_pkg::RAIL_VPPAB] | dbg;
			// VTT tracks the DDR supply
			rail_en.vddrab_en <= en[pwr_pkg::RAIL_VDDR] | dbg;
			rail_en.vttab_en <= en[pwr_pkg::RAIL_VDDR] | dbg;

			sysgood_buf <= delay_done[pwr_pkg::RAIL_VDDR];
			sysgood <= sysgood_buf & ~bmc_boot_complete_n;
			lpc_rst <= sysgood_buf;
			cpu_stby_rst_assert <= ~en[pwr_pkg::RAIL_ATX];
		end
	end

endmodule

/* hw/power_ctrl_top.sv */
/*
 * Standby power sequencer top level
 * Nine-rail staged power-up and power-down with fault shutdown and a
 * byte-wide host register port
 */
`timescale 1ns/1ps

module power_ctrl_top #(
	parameter int DELAY_BITS    = pwr_pkg::DEF_DELAY_BITS,
	parameter int WAIT_BITS     = pwr_pkg::DEF_WAIT_BITS,
	parameter int ATX_WAIT_BITS = pwr_pkg::DEF_ATX_WAIT_BITS
) (
	input  logic                clk_in,
	input  logic                rst_n,
	input  logic                sysen,
	input  pwr_pkg::rail_vec_t  pg,
	input  logic                bmc_boot_complete_n,
	input  pwr_pkg::reg_req_t   host,
	output logic [7:0]          rdata,
	output pwr_pkg::rail_en_t   rail_en,
	output logic                sysgood,
	output logic                lpc_rst,
	output logic                cpu_stby_rst_assert
);

	pwr_pkg::override_t override;
	pwr_pkg::fault_t fault;
	pwr_pkg::rail_vec_t pg_raw;
	pwr_pkg::rail_vec_t pg_s;
	pwr_pkg::rail_vec_t en;
	pwr_pkg::rail_vec_t delay_done;
	pwr_pkg::rail_vec_t fail_detail;
	logic sysen_buf;
	logic sysen_s;
	logic sysen_fall;
	logic settling;
	logic clear_err;

	pg_sync i_pg_sync (
		.clk_in, .rst_n, .sysen, .pg, .override,
		.pg_raw, .pg_s, .sysen_buf, .sysen_s, .sysen_fall
	);

	rail_sequencer #(.DELAY_BITS(DELAY_BITS)) i_rail_sequencer (
		.clk_in, .rst_n, .sysen_s, .pg_s,
		.err_found(fault.err_found), .clear_err,
		.en, .delay_done, .settling
	);

	fault_monitor #(.WAIT_BITS(WAIT_BITS), .ATX_WAIT_BITS(ATX_WAIT_BITS)) i_fault_monitor (
		.clk_in, .rst_n, .en, .pg_s, .pg_raw, .delay_done,
		.settling, .clear_err, .sysen_s, .fault, .fail_detail
	);

	ctrl_regs i_ctrl_regs (
		.clk_in, .rst_n, .host, .sysen_fall, .sysen_buf,
		.en, .pg_raw, .delay_done, .fail_detail, .fault,
		.rdata, .override, .clear_err
	);

	power_outputs i_power_outputs (
		.clk_in, .rst_n, .en, .delay_done, .override, .bmc_boot_complete_n,
		.rail_en, .sysgood, .lpc_rst, .cpu_stby_rst_assert
	);

endmodule

/* bench/power_ctrl_properties.sv */
/*
 * Rail sequencer properties
 * Error shutdown, enable ordering and reset state of the rail enables
 */
`timescale 1ns/1ps

module power_ctrl_properties (
	input logic                clk_in,
	input logic                rst_n,
	input pwr_pkg::rail_vec_t  en,
	input pwr_pkg::rail_vec_t  delay_done,
	input pwr_pkg::rail_vec_t  pg_s,
	input logic                err_found
);

	// Enables drop on the edge after the error latches
	a_error_off: assert property (@(posedge clk_in) disable iff (!rst_n)
		err_found |=> en == '0)
		else $error("Rail enabled while an error is latched");

	for (genvar i = 1; i < pwr_pkg::RAIL_VDDR; i++) begin : g_order
		a_rise_order: assert property (@(posedge clk_in) disable iff (!rst_n)
			$rose(en[i]) |-> $past(delay_done[i-1]) || $past(pg_s[i+1]))
			else $error("Rail %0d enabled without a settled rail below or a good rail above", i);
	end

	a_reset_off: assert property (@(posedge clk_in)
		!rst_n |=> en == '0)
		else $error("Rail enabled during reset");

endmodule

bind rail_sequencer power_ctrl_properties i_power_ctrl_properties (
	.clk_in(clk_in),
	.rst_n(rst_n),
	.en(en),
	.delay_done(delay_done),
	.pg_s(pg_s),
	.err_found(err_found)
);

/* bench/tb_power_ctrl.sv */
/*
 * Testbench for the standby power sequencer
 * Directed tests of power-up, power-down, faults, error clearing and
 * overrides, with a simple per-rail power-good model
 */
`timescale 1ns/1ps

module tb_power_ctrl;

	localparam int HALF_PERIOD = 2;
	localparam int PG_RISE_CYCLES = 4;
	localparam int RAIL_WAIT = 60;
	// All tests together take about 1500 cycles with the short timers
	localparam int TIMEOUT_CYCLES = 6000;

	logic clk_in;
	logic rst_n;
	logic sysen;
	logic bmc_boot_complete_n;
	pwr_pkg::reg_req_t host;
	pwr_pkg::rail_vec_t pg;
	logic [7:0] rdata;
	pwr_pkg::rail_en_t rail_en;
	logic sysgood;
	logic lpc_rst;
	logic cpu_stby_rst_assert;

	pwr_pkg::rail_vec_t pins;
	pwr_pkg::rail_vec_t pg_block;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	power_ctrl_top #(.DELAY_BITS(5), .WAIT_BITS(7), .ATX_WAIT_BITS(8)) i_power_ctrl_top (
		.clk_in, .rst_n, .sysen, .pg, .bmc_boot_complete_n, .host,
		.rdata, .rail_en, .sysgood, .lpc_rst, .cpu_stby_rst_assert
	);

	// Pin enables as one active-high bit per rail
	function automatic pwr_pkg::rail_vec_t rail_pins(input pwr_pkg::rail_en_t r);
		return {r.vddrab_en, r.vppab_en, r.vcsa_en, r.vdda_en, r.vioa_en,
			r.avdd_en, r.vdna_en, r.miscio_en, ~r.atx_en_n};
	endfunction

	assign pins = rail_pins(rail_en);

	initial begin
		clk_in = 1'b0;
		forever #HALF_PERIOD clk_in = ~clk_in;
	end

	// Supply model where power-good follows the pin enable after a ramp
	for (genvar g = 0; g < pwr_pkg::RAIL_COUNT; g++) begin : g_supply
		int age = 0;
		logic good = 1'b0;

		assign pg[g] = good;

		always @(negedge clk_in) begin
			if (!rst_n || !pins[g]) begin
				age <= 0;
				good <= 1'b0;
			end else begin
				if (age < PG_RISE_CYCLES) begin
					age <= age + 1;
				end
				good <= (age >= PG_RISE_CYCLES - 1) && !pg_block[g];
			end
		end
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
		end
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk_in);
		host.wr = 1'b1;
		host.addr = addr;
		host.wdata = data;
		@(negedge clk_in);
		host.wr = 1'b0;
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [7:0] data);
		@(negedge clk_in);
		host.addr = addr;
		// Read data follows the address by one cycle
		@(negedge clk_in);
		data = rdata;
	endtask

	task automatic expect_reg(input string what, input logic [7:0] addr,
		input logic [7:0] expected);
		logic [7:0] value;
		reg_read(addr, value);
		check_value(what, 32'(value), 32'(expected));
	endtask

	task automatic poll_status(input logic [7:0] expected);
		logic [7:0] value;
		int n;
		n = 0;
		reg_read(pwr_pkg::REG_STATUS, value);
		while (value !== expected && n < 10) begin
			reg_read(pwr_pkg::REG_STATUS, value);
			n++;
		end
		check_value("REG_STATUS", 32'(value), 32'(expected));
	endtask

	task automatic wait_rail(input int rail, input logic level);
		pwr_pkg::rail_vec_t mask;
		int n;
		mask = pwr_pkg::rail_vec_t'(1) << rail;
		n = 0;
		while ((((pins & mask) != '0) != level) && n < RAIL_WAIT) begin
			@(negedge clk_in);
			n++;
		end
		if (((pins & mask) != '0) != level) begin
			errors++;
			$display("Rail %0d enable did not go to %0d within %0d cycles", rail, level, RAIL_WAIT);
		end
	endtask

	task automatic wait_all_off(input int limit);
		int n;
		n = 0;
		while (pins != '0 && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if (pins != '0) begin
			errors++;
			$display("Rail enables did not all turn off within %0d cycles", limit);
		end
	endtask

	task automatic wait_sequence_done(input int limit);
		int n;
		n = 0;
		while (lpc_rst !== 1'b1 && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if (lpc_rst !== 1'b1) begin
			errors++;
			$display("Power-up did not complete within %0d cycles", limit);
		end
	endtask

	task automatic test_reset_state();
		// Only the active-low ATX enable is high
		check_value("rail_en after reset", 32'(rail_en), 32'h200);
		check_value("sysgood after reset", 32'(sysgood), 0);
		check_value("lpc_rst after reset", 32'(lpc_rst), 0);
		check_value("cpu_stby_rst_assert after reset", 32'(cpu_stby_rst_assert), 1);
		check_value("rdata after reset", 32'(rdata), 0);
		expect_reg("REG_VERSION", pwr_pkg::REG_VERSION, 8'h00);
		expect_reg("REG_VENDOR0", pwr_pkg::REG_VENDOR0, 8'h52);
		expect_reg("REG_VENDOR1", pwr_pkg::REG_VENDOR1, 8'h43);
		expect_reg("REG_VENDOR2", pwr_pkg::REG_VENDOR2, 8'h53);
		expect_reg("REG_VENDOR3", pwr_pkg::REG_VENDOR3, 8'h20);
	endtask

	task automatic test_power_up();
		int n;
		sysen = 1'b1;
		for (int i = 0; i < pwr_pkg::RAIL_COUNT; i++) begin
			wait_rail(i, 1'b1);
			// No rail above this one may be on yet
			check_value($sformatf("pins at rail %0d rise", i), 32'(pins), (1 << (i + 1)) - 1);
			if (i > 0) begin
				check_value($sformatf("pg of rail %0d", i - 1), 32'((pg >> (i - 1)) & 1), 1);
			end
		end
		wait_sequence_done(100);
		check_value("sysgood before BMC boot", 32'(sysgood), 0);
		bmc_boot_complete_n = 1'b0;
		n = 0;
		while (sysgood !== 1'b1 && n < 10) begin
			@(negedge clk_in);
			n++;
		end
		check_value("sysgood after BMC boot", 32'(sysgood), 1);
		check_value("vttab_en", 32'(rail_en.vttab_en), 1);
		// Sysen seen and last rail settled
		expect_reg("REG_STATUS after power-up", pwr_pkg::REG_STATUS, 8'h03);
		expect_reg("REG_EN_LO", pwr_pkg::REG_EN_LO, 8'hFF);
		expect_reg("REG_EN_HI", pwr_pkg::REG_EN_HI, 8'h01);
	endtask

	task automatic test_power_down();
		sysen = 1'b0;
		for (int i = pwr_pkg::RAIL_COUNT - 1; i >= 0; i--) begin
			wait_rail(i, 1'b0);
			check_value($sformatf("pins at rail %0d fall", i), 32'(pins), (1 << i) - 1);
			if (i < pwr_pkg::RAIL_COUNT - 1) begin
				check_value($sformatf("pg of rail %0d", i + 1), 32'((pg >> (i + 1)) & 1), 0);
			end
		end
		check_value("rail_en after power-down", 32'(rail_en), 32'h200);
		check_value("cpu_stby_rst_assert after power-down", 32'(cpu_stby_rst_assert), 1);
		check_value("lpc_rst after power-down", 32'(lpc_rst), 0);
		check_value("sysgood after power-down", 32'(sysgood), 0);
		poll_status(8'h00);
	endtask

	task automatic test_wait_timeout();
		pg_block = pwr_pkg::rail_vec_t'(1) << pwr_pkg::RAIL_AVDD;
		sysen = 1'b1;
		for (int i = pwr_pkg::RAIL_ATX; i <= pwr_pkg::RAIL_AVDD; i++) begin
			wait_rail(i, 1'b1);
		end
		wait_all_off(200);
		// wait_err, err_found and sysen_buf
		expect_reg("REG_STATUS after timeout", pwr_pkg::REG_STATUS, 8'h16);
		expect_reg("REG_FAIL_LO after timeout", pwr_pkg::REG_FAIL_LO, 8'h08);
		expect_reg("REG_FAIL_HI after timeout", pwr_pkg::REG_FAIL_HI, 8'h00);
		reg_write(pwr_pkg::REG_CLR_ERR, 8'hA5);
		// Error bits gone while sysen is still high
		expect_reg("REG_STATUS after clear", pwr_pkg::REG_STATUS, 8'h02);
		expect_reg("REG_FAIL_LO after clear", pwr_pkg::REG_FAIL_LO, 8'h00);
		sysen = 1'b0;
		pg_block = '0;
		wait_all_off(100);
		poll_status(8'h00);
	endtask

	task automatic test_operation_error();
		sysen = 1'b1;
		wait_sequence_done(400);
		pg_block = pwr_pkg::rail_vec_t'(1) << pwr_pkg::RAIL_VDDA;
		wait_all_off(100);
		// operation_err, err_found and sysen_buf
		expect_reg("REG_STATUS after lost pg", pwr_pkg::REG_STATUS, 8'h0E);
		expect_reg("REG_FAIL_LO after lost pg", pwr_pkg::REG_FAIL_LO, 8'h20);
		expect_reg("REG_FAIL_HI after lost pg", pwr_pkg::REG_FAIL_HI, 8'h00);
		check_value("lpc_rst after lost pg", 32'(lpc_rst), 0);
		check_value("sysgood after lost pg", 32'(sysgood), 0);
		sysen = 1'b0;
		pg_block = '0;
		poll_status(8'h00);
		expect_reg("REG_FAIL_LO after sysen drop", pwr_pkg::REG_FAIL_LO, 8'h00);
	endtask

	task automatic test_overrides();
		int n;
		reg_write(pwr_pkg::REG_OVERRIDE, 8'h10);
		n = 0;
		while ((pins & 9'h1FE) != 9'h1FE && n < 10) begin
			@(negedge clk_in);
			n++;
		end
		check_value("forced non-ATX pins", 32'(pins & 9'h1FE), 32'h1FE);
		check_value("atx_en_n under debug force", 32'(rail_en.atx_en_n), 1);
		check_value("vttab_en under debug force", 32'(rail_en.vttab_en), 1);
		reg_write(pwr_pkg::REG_OVERRIDE, 8'h00);
		wait_all_off(200);
		// ATX force stands in for sysen
		reg_write(pwr_pkg::REG_OVERRIDE, 8'h01);
		wait_sequence_done(400);
		expect_reg("REG_OVERRIDE", pwr_pkg::REG_OVERRIDE, 8'h01);
		expect_reg("REG_STATUS under ATX force", pwr_pkg::REG_STATUS, 8'h03);
		reg_write(pwr_pkg::REG_OVERRIDE, 8'h00);
		wait_all_off(200);
		poll_status(8'h00);
	endtask

	initial begin
		rst_n = 1'b0;
		sysen = 1'b0;
		bmc_boot_complete_n = 1'b1;
		host = '0;
		pg_block = '0;
		repeat (5) @(negedge clk_in);
		rst_n = 1'b1;

		test_reset_state();
		test_power_up();
		test_power_down();
		test_wait_timeout();
		test_operation_error();
		test_overrides();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* all.f */
hw/pwr_pkg.sv
hw/pg_sync.sv
hw/rail_sequencer.sv
hw/fault_monitor.sv
hw/ctrl_regs.sv
hw/power_outputs.sv
hw/power_ctrl_top.sv
bench/power_ctrl_properties.sv
bench/tb_power_ctrl.sv

/* Makefile */
# Verilator simulation of the power sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_power_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
